/* verification/ctrl_vectors.txt */
# I pc inst gap | W rob fault | X stall_mode(0 off,1 held,2 random) | F expect full
# D op prd prs1 prs2 rob imm | C rob rd prd old_prd wen | S rob pc   (all hex)
I 00 00500093 0
I 04 00308113 2
I 08 002081b3 0
I 0c 00312423 0
I 10 fff08093 0
D 1 20 00 05 0 00000005
D 1 21 20 03 1 00000003
D 0 22 20 21 2 00000000
D 3 00 21 22 3 00000008
D 1 23 20 1f 4 ffffffff
W 2 0
W 0 0
W 1 0
W 4 0
W 3 0
C 0 01 20 01 1
C 1 02 21 02 1
C 2 03 22 03 1
C 3 08 00 08 0
C 4 01 23 20 1
X 1
I 100 02000393 0
I 104 04000413 0
I 108 06000493 0
I 10c 08000513 0
I 110 0a000593 0
I 114 0c000613 0
F
X 2
D 1 01 00 00 5 00000020
D 1 02 00 00 6 00000040
D 1 03 00 00 7 00000060
D 1 20 00 00 0 00000080
D 1 24 00 00 1 000000a0
D 1 25 00 00 2 000000c0
W 7 0
W 5 0
W 6 0
W 2 0
W 0 0
W 1 0
C 5 07 01 07 1
C 6 08 02 08 1
C 7 09 03 09 1
C 0 0a 20 0a 1
C 1 0b 24 0b 1
C 2 0c 25 0c 1
I 14 00110213 0
I 18 00220293 0
D 1 07 21 23 3 00000001
D 1 08 07 21 4 00000002
W 3 1
S 3 00000014
I 40 00120333 0
D 0 07 04 23 0 00000000
W 0 0
C 0 06 07 06 1
I 44 0000007f 0
S 1 00000044

/* sim.f */
design/ctrl_pkg.sv
design/inst_buffer.sv
design/decoder.sv
design/renamer.sv
design/dispatch_unit.sv
design/reorder_buffer.sv
design/ctrl_block.sv
verification/ctrl_block_sva.sv
verification/ctrl_block_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= ctrl_block_tb
RTL_TOP   ?= ctrl_block
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only -Wall --timing
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verification/ctrl_block_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module ctrl_block_tb;

    localparam int TIMEOUT = 200;
    localparam int DRAIN   = 20;

    logic                      clk;
    logic                      rst_n;
    logic                      i_inst_vld;
    ctrl_pkg::fetch_entry_t    i_inst;
    logic                      o_stall;
    logic                      i_exe_stall;
    logic                      o_disp_vld;
    ctrl_pkg::disp_info_t      o_disp;
    ctrl_pkg::rob_idx_t        i_imm_rd_idx;
    logic [ctrl_pkg::XLEN-1:0] o_imm_rd_data;
    logic                      i_wb_vld;
    ctrl_pkg::wb_info_t        i_wb;
    logic                      o_commit_vld;
    ctrl_pkg::commit_info_t    o_commit;
    logic                      o_squash_vld;
    ctrl_pkg::squash_info_t    o_squash;

    // observed events in arrival order
    ctrl_pkg::disp_info_t   disp_q [$];
    logic [31:0]            imm_q [$];
    ctrl_pkg::commit_info_t commit_q [$];
    ctrl_pkg::squash_info_t squash_q [$];

    logic               imm_pend;
    ctrl_pkg::rob_idx_t imm_idx;
    int                 stall_mode;
    logic [31:0]        lfsr;
    logic               rnd_a;
    logic               rnd_b;
    int                 cur_line;

    ctrl_block dut_i (
        .clk           ( clk           ),
        .i_rst_n       ( rst_n         ),
        .i_inst_vld    ( i_inst_vld    ),
        .i_inst        ( i_inst        ),
        .o_stall       ( o_stall       ),
        .i_exe_stall   ( i_exe_stall   ),
        .o_disp_vld    ( o_disp_vld    ),
        .o_disp        ( o_disp        ),
        .i_imm_rd_idx  ( i_imm_rd_idx  ),
        .o_imm_rd_data ( o_imm_rd_data ),
        .i_wb_vld      ( i_wb_vld      ),
        .i_wb          ( i_wb          ),
        .o_commit_vld  ( o_commit_vld  ),
        .o_commit      ( o_commit      ),
        .o_squash_vld  ( o_squash_vld  ),
        .o_squash      ( o_squash      )
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            $display("error: %s (vector line %0d) expected %h actual %h",
                     name, cur_line, exp, act);
            fail_run("value mismatch");
        end
    endtask

    // exe stall and immediate read index on the falling edge
    always @(negedge clk) begin
        if (stall_mode == 2) begin
            lfsr  = lfsr_step(lfsr);
            rnd_a = lfsr[0];
            lfsr  = lfsr_step(lfsr);
            rnd_b = lfsr[0];
            i_exe_stall = rnd_a && rnd_b;
        end else begin
            i_exe_stall = (stall_mode == 1);
        end
        i_imm_rd_idx = imm_idx;
    end

    // immediate is read back one cycle after the dispatch
    always @(posedge clk) begin
        if (rst_n) begin
            if (imm_pend) begin
                imm_q.push_back(o_imm_rd_data);
            end
            imm_pend = 1'b0;
            if (o_disp_vld && !i_exe_stall) begin
                disp_q.push_back(o_disp);
                imm_pend = 1'b1;
                imm_idx  = o_disp.rob_idx;
            end
            if (o_commit_vld) begin
                commit_q.push_back(o_commit);
            end
            if (o_squash_vld) begin
                squash_q.push_back(o_squash);
            end
        end
    end

    task automatic fetch_inst(input logic [31:0] pc, input logic [31:0] word, input int gap);
        int t;
        for (t = 0; t < TIMEOUT && o_stall; t++) @(negedge clk);
        if (o_stall) fail_run("fetch blocked: o_stall stayed high");
        i_inst_vld  = 1'b1;
        i_inst.pc   = pc;
        i_inst.inst = word;
        @(negedge clk);
        i_inst_vld = 1'b0;
        repeat (gap) @(negedge clk);
    endtask

    task automatic expect_disp(input logic [31:0] f[6]);
        int t;
        ctrl_pkg::disp_info_t d;
        logic [31:0] imm;
        for (t = 0; t < TIMEOUT && imm_q.size() == 0; t++) @(negedge clk);
        if (imm_q.size() == 0) fail_run("timeout waiting for a dispatch");
        d   = disp_q.pop_front();
        imm = imm_q.pop_front();
        check("dispatch op", 64'(f[0]), 64'(d.op));
        check("dispatch prd", 64'(f[1]), 64'(d.prd));
        check("dispatch prs1", 64'(f[2]), 64'(d.prs1));
        check("dispatch prs2", 64'(f[3]), 64'(d.prs2));
        check("dispatch rob index", 64'(f[4]), 64'(d.rob_idx));
        check("immediate readback", 64'(f[5]), 64'(imm));
    endtask

    task automatic expect_commit(input logic [31:0] f[6]);
        int t;
        ctrl_pkg::commit_info_t c;
        for (t = 0; t < TIMEOUT && commit_q.size() == 0; t++) @(negedge clk);
        if (commit_q.size() == 0) fail_run("timeout waiting for a commit");
        c = commit_q.pop_front();
        check("commit rob index", 64'(f[0]), 64'(c.rob_idx));
        check("commit rd", 64'(f[1]), 64'(c.rd));
        check("commit prd", 64'(f[2]), 64'(c.prd));
        check("commit old prd", 64'(f[3]), 64'(c.old_prd));
        check("commit wen", 64'(f[4]), 64'(c.wen));
    endtask

    task automatic expect_squash(input logic [31:0] f[6]);
        int t;
        ctrl_pkg::squash_info_t s;
        for (t = 0; t < TIMEOUT && squash_q.size() == 0; t++) @(negedge clk);
        if (squash_q.size() == 0) fail_run("timeout waiting for a squash");
        s = squash_q.pop_front();
        check("squash rob index", 64'(f[0]), 64'(s.rob_idx));
        check("squash pc", 64'(f[1]), 64'(s.pc));
    endtask

    task automatic expect_full();
        int t;
        for (t = 0; t < TIMEOUT && !o_stall; t++) @(negedge clk);
        if (!o_stall) fail_run("o_stall never rose with the buffer full");
    endtask

    initial begin
        int fd;
        string line;
        byte code;
        logic [31:0] f[6];
        clk          = 1'b0;
        rst_n        = 1'b0;
        i_inst_vld   = 1'b0;
        i_inst       = '0;
        i_exe_stall  = 1'b0;
        i_imm_rd_idx = '0;
        i_wb_vld     = 1'b0;
        i_wb         = '0;
        imm_pend     = 1'b0;
        imm_idx      = '0;
        stall_mode   = 0;
        lfsr         = 32'he960_9272;
        cur_line     = 0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check("idle dispatch after reset", 64'd0, 64'(o_disp_vld));
        check("idle commit after reset", 64'd0, 64'(o_commit_vld));
        check("idle squash after reset", 64'd0, 64'(o_squash_vld));
        check("idle stall after reset", 64'd0, 64'(o_stall));
        fd = $fopen("verification/ctrl_vectors.txt", "r");
        if (fd == 0) fail_run("cannot open the vector file");
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            cur_line++;
            if (line.len() < 2 || line[0] == "#") continue;
            f = '{default: '0};
            void'($sscanf(line, "%c %h %h %h %h %h %h", code, f[0], f[1], f[2], f[3],
                          f[4], f[5]));
            case (code)
                "I": fetch_inst(f[0], f[1], int'(f[2]));
                "D": expect_disp(f);
                "C": expect_commit(f);
                "S": expect_squash(f);
                "F": expect_full();
                "W": begin
                    i_wb_vld      = 1'b1;
                    i_wb.rob_idx  = f[0][2:0];
                    i_wb.fault    = f[1][0];
                    @(negedge clk);
                    i_wb_vld = 1'b0;
                end
                "X": begin
                    // mode changes on the rising edge so the stall driver sees it next
                    @(posedge clk);
                    stall_mode = int'(f[0]);
                    @(negedge clk);
                end
                default: fail_run($sformatf("unknown record on vector line %0d", cur_line));
            endcase
        end
        $fclose(fd);
        // nothing further may come out of the DUT
        repeat (DRAIN) @(negedge clk);
        check("leftover dispatches", 64'd0, 64'(disp_q.size()));
        check("leftover commits", 64'd0, 64'(commit_q.size()));
        check("leftover squashes", 64'd0, 64'(squash_q.size()));
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* verification/ctrl_block_sva.sv */
`timescale 1ns/100ps
`default_nettype none

module ctrl_block_sva (
    input wire                  clk,
    input wire                  i_rst_n,
    input wire                  o_squash_vld,
    input wire                  o_commit_vld,
    input wire                  o_disp_vld,
    input wire                  i_exe_stall,
    input ctrl_pkg::disp_info_t o_disp
);

    // a faulted head never retires
    a_no_commit_on_squash: assert property (@(posedge clk) disable iff (!i_rst_n)
        !(o_squash_vld && o_commit_vld))
        else $error("squash and commit in the same cycle");

    a_squash_one_cycle: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_squash_vld |=> !o_squash_vld)
        else $error("squash held longer than one cycle");

    // held dispatch keeps its payload
    a_disp_stable: assert property (@(posedge clk) disable iff (!i_rst_n)
        (o_disp_vld && i_exe_stall && !o_squash_vld) |=> $stable(o_disp))
        else $error("dispatch payload changed while stalled");

endmodule

bind ctrl_block ctrl_block_sva sva_i (
    .clk          ( clk          ),
    .i_rst_n      ( i_rst_n      ),
    .o_squash_vld ( o_squash_vld ),
    .o_commit_vld ( o_commit_vld ),
    .o_disp_vld   ( o_disp_vld   ),
    .i_exe_stall  ( i_exe_stall  ),
    .o_disp       ( o_disp       )
);

`default_nettype wire

/* design/ctrl_block.sv */
`timescale 1ns/100ps
`default_nettype none

// buffer -> decode -> rename -> dispatch -> rob
module ctrl_block (
    input  wire                        clk,
    input  wire                        i_rst_n,

    // fetch side
    input  wire                        i_inst_vld,
    input  ctrl_pkg::fetch_entry_t     i_inst,
    output logic                       o_stall,

    // execution block
    input  wire                        i_exe_stall,
    output logic                       o_disp_vld,
    output ctrl_pkg::disp_info_t       o_disp,
    input  ctrl_pkg::rob_idx_t         i_imm_rd_idx,
    output logic [ctrl_pkg::XLEN-1:0]  o_imm_rd_data,
    input  wire                        i_wb_vld,
    input  ctrl_pkg::wb_info_t         i_wb,

    // retire and squash
    output logic                       o_commit_vld,
    output ctrl_pkg::commit_info_t     o_commit,
    output logic                       o_squash_vld,
    output ctrl_pkg::squash_info_t     o_squash
);

    logic                   buf_vld;
    ctrl_pkg::fetch_entry_t buf_data;
    logic                   dec_deq;
    logic                   dec_vld;
    ctrl_pkg::dec_info_t    dec_info;
    logic                   ren_stall;
    logic                   ren_vld;
    ctrl_pkg::ren_info_t    ren_info;
    logic                   disp_stall;
    logic                   rob_can_insert;
    logic                   rob_insert;
    logic                   rob_fault;
    ctrl_pkg::rob_idx_t     rob_alloc_idx;

    inst_buffer #(
        .DEPTH      ( 4 )
    ) u_inst_buffer (
        .clk        ( clk          ),
        .i_rst_n    ( i_rst_n      ),
        .i_flush    ( o_squash_vld ),
        .i_enq_vld  ( i_inst_vld   ),
        .i_enq_data ( i_inst       ),
        .o_full     ( o_stall      ),
        .o_deq_vld  ( buf_vld      ),
        .o_deq_data ( buf_data     ),
        .i_deq      ( dec_deq      )
    );

    decoder u_decoder (
        .clk        ( clk          ),
        .i_rst_n    ( i_rst_n      ),
        .i_squash   ( o_squash_vld ),
        .i_inst_vld ( buf_vld      ),
        .i_inst     ( buf_data     ),
        .o_deq      ( dec_deq      ),
        .i_stall    ( ren_stall    ),
        .o_dec_vld  ( dec_vld      ),
        .o_dec      ( dec_info     )
    );

    renamer u_renamer (
        .clk          ( clk          ),
        .i_rst_n      ( i_rst_n      ),
        .i_squash     ( o_squash_vld ),
        .i_dec_vld    ( dec_vld      ),
        .i_dec        ( dec_info     ),
        .o_stall      ( ren_stall    ),
        .i_stall      ( disp_stall   ),
        .o_ren_vld    ( ren_vld      ),
        .o_ren        ( ren_info     ),
        .i_commit_vld ( o_commit_vld ),
        .i_commit     ( o_commit     )
    );

    dispatch_unit u_dispatch_unit (
        .clk              ( clk            ),
        .i_rst_n          ( i_rst_n        ),
        .i_ren_vld        ( ren_vld        ),
        .i_ren            ( ren_info       ),
        .o_stall          ( disp_stall     ),
        .i_rob_can_insert ( rob_can_insert ),
        .o_rob_insert     ( rob_insert     ),
        .o_rob_fault      ( rob_fault      ),
        .i_rob_idx        ( rob_alloc_idx  ),
        .i_exe_stall      ( i_exe_stall    ),
        .o_disp_vld       ( o_disp_vld     ),
        .o_disp           ( o_disp         ),
        .i_imm_rd_idx     ( i_imm_rd_idx   ),
        .o_imm_rd_data    ( o_imm_rd_data  )
    );

    reorder_buffer u_reorder_buffer (
        .clk            ( clk            ),
        .i_rst_n        ( i_rst_n        ),
        .o_can_insert   ( rob_can_insert ),
        .i_insert       ( rob_insert     ),
        .i_insert_fault ( rob_fault      ),
        .i_insert_info  ( ren_info       ),
        .o_alloc_idx    ( rob_alloc_idx  ),
        .i_wb_vld       ( i_wb_vld       ),
        .i_wb           ( i_wb           ),
        .o_commit_vld   ( o_commit_vld   ),
        .o_commit       ( o_commit       ),
        .o_squash_vld   ( o_squash_vld   ),
        .o_squash       ( o_squash       )
    );

endmodule

`default_nettype wire

/* design/reorder_buffer.sv */
`timescale 1ns/100ps
`default_nettype none

module reorder_buffer (
    input  wire                    clk,
    input  wire                    i_rst_n,
    output logic                   o_can_insert,
    input  wire                    i_insert,
    input  wire                    i_insert_fault,
    input  ctrl_pkg::ren_info_t    i_insert_info,
    output ctrl_pkg::rob_idx_t     o_alloc_idx,
    input  wire                    i_wb_vld,
    input  ctrl_pkg::wb_info_t     i_wb,
    output logic                   o_commit_vld,
    output ctrl_pkg::commit_info_t o_commit,
    output logic                   o_squash_vld,
    output ctrl_pkg::squash_info_t o_squash
);

    ctrl_pkg::rob_state_e   state [ctrl_pkg::ROB_SIZE];
    logic [ctrl_pkg::XLEN-1:0] pc_q [ctrl_pkg::ROB_SIZE];
    ctrl_pkg::commit_info_t cmt_q [ctrl_pkg::ROB_SIZE];
    ctrl_pkg::rob_idx_t     head;
    ctrl_pkg::rob_idx_t     tail;
    logic [$clog2(ctrl_pkg::ROB_SIZE):0] count;
    logic                   not_empty;
    logic                   do_ins;

    assign not_empty    = (count != '0);
    assign o_alloc_idx  = tail;
    assign o_commit_vld = not_empty && (state[head] == ctrl_pkg::ROB_DONE);
    assign o_commit     = cmt_q[head];
    assign o_squash_vld = not_empty && (state[head] == ctrl_pkg::ROB_FAULT);

    assign o_squash.rob_idx = head;
    assign o_squash.pc      = pc_q[head];

    // nothing is accepted in the squash cycle
    assign o_can_insert = (count != ctrl_pkg::ROB_SIZE) && !o_squash_vld;
    assign do_ins       = i_insert && o_can_insert;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            for (int k = 0; k < ctrl_pkg::ROB_SIZE; k++) begin
                state[k] <= ctrl_pkg::ROB_BUSY;
            end
        end else if (o_squash_vld) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (i_wb_vld) begin
                state[i_wb.rob_idx] <= i_wb.fault ? ctrl_pkg::ROB_FAULT : ctrl_pkg::ROB_DONE;
            end
            if (do_ins) begin
                state[tail] <= i_insert_fault ? ctrl_pkg::ROB_FAULT : ctrl_pkg::ROB_BUSY;
                tail        <= tail + 1'b1;
            end
            if (o_commit_vld) begin
                head <= head + 1'b1;
            end
            count <= count + do_ins - o_commit_vld;
        end
    end

    // entry payload
    always_ff @(posedge clk) begin
        if (do_ins) begin
            pc_q[tail]          <= i_insert_info.dec.pc;
            cmt_q[tail].rob_idx <= tail;
            cmt_q[tail].rd      <= i_insert_info.dec.rd;
            cmt_q[tail].prd     <= i_insert_info.prd;
            cmt_q[tail].old_prd <= i_insert_info.old_prd;
            cmt_q[tail].wen     <= i_insert_info.dec.rd_wen;
        end
    end

endmodule

`default_nettype wire

/* design/dispatch_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module dispatch_unit (
    input  wire                        clk,
    input  wire                        i_rst_n,
    input  wire                        i_ren_vld,
    input  ctrl_pkg::ren_info_t        i_ren,
    output logic                       o_stall,
    input  wire                        i_rob_can_insert,
    output logic                       o_rob_insert,
    output logic                       o_rob_fault,
    input  ctrl_pkg::rob_idx_t         i_rob_idx,
    input  wire                        i_exe_stall,
    output logic                       o_disp_vld,
    output ctrl_pkg::disp_info_t       o_disp,
    input  ctrl_pkg::rob_idx_t         i_imm_rd_idx,
    output logic [ctrl_pkg::XLEN-1:0]  o_imm_rd_data
);

    logic [ctrl_pkg::XLEN-1:0] imm_buf [ctrl_pkg::ROB_SIZE];
    logic [ctrl_pkg::ROB_SIZE-1:0] imm_vld;
    logic                          illegal;

    assign illegal = (i_ren.dec.op == ctrl_pkg::OP_ILLEGAL);

    // upstream holds unless both rob and execution can take it
    assign o_stall      = !i_rob_can_insert || i_exe_stall;
    assign o_rob_insert = i_ren_vld && !o_stall;
    assign o_rob_fault  = illegal;

    // illegal ops go straight to the rob as faulted
    assign o_disp_vld     = i_ren_vld && i_rob_can_insert && !illegal;
    assign o_disp.op      = i_ren.dec.op;
    assign o_disp.prd     = i_ren.prd;
    assign o_disp.prs1    = i_ren.prs1;
    assign o_disp.prs2    = i_ren.prs2;
    assign o_disp.rob_idx = i_rob_idx;

    assign o_imm_rd_data = imm_vld[i_imm_rd_idx] ? imm_buf[i_imm_rd_idx] : '0;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            imm_vld <= '0;
        end else if (o_rob_insert) begin
            imm_vld[i_rob_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (o_rob_insert) begin
            imm_buf[i_rob_idx] <= i_ren.dec.imm;
        end
    end

endmodule

`default_nettype wire

/* design/renamer.sv */
`timescale 1ns/100ps
`default_nettype none

module renamer (
    input  wire                    clk,
    input  wire                    i_rst_n,
    input  wire                    i_squash,
    input  wire                    i_dec_vld,
    input  ctrl_pkg::dec_info_t    i_dec,
    output logic                   o_stall,
    input  wire                    i_stall,
    output logic                   o_ren_vld,
    output ctrl_pkg::ren_info_t    o_ren,
    input  wire                    i_commit_vld,
    input  ctrl_pkg::commit_info_t i_commit
);

    ctrl_pkg::preg_t spec_rat [ctrl_pkg::AREG_NUM];
    ctrl_pkg::preg_t comm_rat [ctrl_pkg::AREG_NUM];
    logic [ctrl_pkg::PREG_NUM-1:0] free_q;
    logic [ctrl_pkg::PREG_NUM-1:0] comm_used;
    ctrl_pkg::preg_t               free_idx;
    logic                          has_free;
    logic                          adv;
    logic                          take;
    ctrl_pkg::ren_info_t           ren_d;

    // lowest numbered free register
    always_comb begin
        free_idx = '0;
        has_free = 1'b0;
        for (int k = ctrl_pkg::PREG_NUM - 1; k >= 0; k--) begin
            if (free_q[k]) begin
                free_idx = ctrl_pkg::preg_t'(k);
                has_free = 1'b1;
            end
        end
    end

    // registers held by the committed state for the squash rebuild
    always_comb begin
        comm_used = '0;
        for (int k = 0; k < ctrl_pkg::AREG_NUM; k++) begin
            comm_used[comm_rat[k]] = 1'b1;
        end
    end

    assign adv     = !o_ren_vld || !i_stall;
    assign o_stall = !has_free || !adv;
    assign take    = i_dec_vld && !o_stall && !i_squash;

    always_comb begin
        ren_d.dec     = i_dec;
        ren_d.prs1    = spec_rat[i_dec.rs1];
        ren_d.prs2    = spec_rat[i_dec.rs2];
        ren_d.old_prd = spec_rat[i_dec.rd];
        ren_d.prd     = i_dec.rd_wen ? free_idx : '0;
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_ren_vld <= 1'b0;
            for (int k = 0; k < ctrl_pkg::AREG_NUM; k++) begin
                spec_rat[k] <= ctrl_pkg::preg_t'(k);
                comm_rat[k] <= ctrl_pkg::preg_t'(k);
            end
            for (int k = 0; k < ctrl_pkg::PREG_NUM; k++) begin
                free_q[k] <= (k >= ctrl_pkg::AREG_NUM);
            end
        end else if (i_squash) begin
            o_ren_vld <= 1'b0;
            spec_rat  <= comm_rat;
            free_q    <= ~comm_used;
        end else begin
            if (adv) begin
                o_ren_vld <= i_dec_vld && has_free;
            end
            if (take && i_dec.rd_wen) begin
                spec_rat[i_dec.rd] <= free_idx;
                free_q[free_idx]   <= 1'b0;
            end
            // retire frees the mapping it replaced
            if (i_commit_vld && i_commit.wen) begin
                comm_rat[i_commit.rd]    <= i_commit.prd;
                free_q[i_commit.old_prd] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (adv) begin
            o_ren <= ren_d;
        end
    end

endmodule

`default_nettype wire

/* design/decoder.sv */
`timescale 1ns/100ps
`default_nettype none

module decoder (
    input  wire                    clk,
    input  wire                    i_rst_n,
    input  wire                    i_squash,
    input  wire                    i_inst_vld,
    input  ctrl_pkg::fetch_entry_t i_inst,
    output logic                   o_deq,
    input  wire                    i_stall,
    output logic                   o_dec_vld,
    output ctrl_pkg::dec_info_t    o_dec
);

    ctrl_pkg::dec_info_t dec_d;
    logic [31:0]         iw;
    logic                load_en;

    assign iw = i_inst.inst;

    // stage can take a new entry when empty or draining
    assign load_en = !o_dec_vld || !i_stall;
    assign o_deq   = i_inst_vld && load_en && !i_squash;

    always_comb begin
        dec_d.pc     = i_inst.pc;
        dec_d.rd     = iw[11:7];
        dec_d.rs1    = iw[19:15];
        dec_d.rs2    = iw[24:20];
        dec_d.op     = ctrl_pkg::OP_ILLEGAL;
        dec_d.rd_wen = 1'b0;
        dec_d.imm    = '0;
        case (iw[6:0])
            7'b0110011: begin
                dec_d.op     = ctrl_pkg::OP_ALU;
                dec_d.rd_wen = 1'b1;
            end
            7'b0010011: begin
                dec_d.op     = ctrl_pkg::OP_ALU_IMM;
                dec_d.rd_wen = 1'b1;
                dec_d.imm    = {{20{iw[31]}}, iw[31:20]};
            end
            7'b0000011: begin
                dec_d.op     = ctrl_pkg::OP_LOAD;
                dec_d.rd_wen = 1'b1;
                dec_d.imm    = {{20{iw[31]}}, iw[31:20]};
            end
            7'b0100011: begin
                dec_d.op  = ctrl_pkg::OP_STORE;
                dec_d.imm = {{20{iw[31]}}, iw[31:25], iw[11:7]};
            end
            7'b1100011: begin
                dec_d.op  = ctrl_pkg::OP_BRANCH;
                dec_d.imm = {{19{iw[31]}}, iw[31], iw[7], iw[30:25], iw[11:8], 1'b0};
            end
            default: begin
                dec_d.op = ctrl_pkg::OP_ILLEGAL;
            end
        endcase
        // x0 is never renamed
        if (dec_d.rd == '0) begin
            dec_d.rd_wen = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_dec_vld <= 1'b0;
        end else if (i_squash) begin
            o_dec_vld <= 1'b0;
        end else if (load_en) begin
            o_dec_vld <= i_inst_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (load_en) begin
            o_dec <= dec_d;
        end
    end

endmodule

`default_nettype wire

/* design/inst_buffer.sv */
`timescale 1ns/100ps
`default_nettype none

module inst_buffer #(
    parameter int DEPTH = 4
) (
    input  wire                    clk,
    input  wire                    i_rst_n,
    input  wire                    i_flush,
    input  wire                    i_enq_vld,
    input  ctrl_pkg::fetch_entry_t i_enq_data,
    output logic                   o_full,
    output logic                   o_deq_vld,
    output ctrl_pkg::fetch_entry_t o_deq_data,
    input  wire                    i_deq
);

    ctrl_pkg::fetch_entry_t mem [DEPTH];
    logic [$clog2(DEPTH)-1:0] wr_ptr;
    logic [$clog2(DEPTH)-1:0] rd_ptr;
    logic [$clog2(DEPTH):0]   count;
    logic                     do_enq;
    logic                     do_deq;

    assign o_full     = (count == DEPTH);
    assign o_deq_vld  = (count != '0);
    assign o_deq_data = mem[rd_ptr];

    // enqueue is dropped while full
    assign do_enq = i_enq_vld && !o_full;
    assign do_deq = i_deq && o_deq_vld;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (i_flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_enq) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_deq) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + do_enq - do_deq;
        end
    end

    always_ff @(posedge clk) begin
        if (do_enq) begin
            mem[wr_ptr] <= i_enq_data;
        end
    end

endmodule

`default_nettype wire

/* design/ctrl_pkg.sv */
`default_nettype none

package ctrl_pkg;

    localparam int XLEN     = 32;
    localparam int AREG_NUM = 32;
    localparam int PREG_NUM = 48;
    localparam int ROB_SIZE = 8;

    typedef logic [4:0] areg_t;
    typedef logic [5:0] preg_t;
    typedef logic [2:0] rob_idx_t;

    typedef enum logic [2:0] {
        OP_ALU,
        OP_ALU_IMM,
        OP_LOAD,
        OP_STORE,
        OP_BRANCH,
        OP_ILLEGAL
    } op_class_e;

    typedef enum logic [1:0] {
        ROB_BUSY,
        ROB_DONE,
        ROB_FAULT
    } rob_state_e;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [31:0]     inst;
    } fetch_entry_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        op_class_e       op;
        areg_t           rd;
        areg_t           rs1;
        areg_t           rs2;
        logic            rd_wen;
        logic [XLEN-1:0] imm;
    } dec_info_t;

    typedef struct packed {
        dec_info_t dec;
        preg_t     prd;
        preg_t     prs1;
        preg_t     prs2;
        preg_t     old_prd;
    } ren_info_t;

    // record handed to the execution block
    typedef struct packed {
        op_class_e op;
        preg_t     prd;
        preg_t     prs1;
        preg_t     prs2;
        rob_idx_t  rob_idx;
    } disp_info_t;

    typedef struct packed {
        rob_idx_t rob_idx;
        logic     fault;
    } wb_info_t;

    typedef struct packed {
        rob_idx_t rob_idx;
        areg_t    rd;
        preg_t    prd;
        preg_t    old_prd;
        logic     wen;
    } commit_info_t;

    typedef struct packed {
        rob_idx_t        rob_idx;
        logic [XLEN-1:0] pc;
    } squash_info_t;

endpackage

`default_nettype wire
